//--- mem_patterns.txt
# F  vpn pfn present rw pcd
# A  v rd_v rd_addr rd_size wr_v wr_addr wr_size cs(jmp near far ld df)
# ME or EX  stage_v p1_v p1_ra p1_size p2_v p2_ra p2_size
# X  rd1 rd2 wr1 wr2 as (v pcd ra size), flags(page_fault gprot dep_stall jmp_stall ld_df)
# empty tlb after reset
A 1 1 00012344 2 0 00000000 0 00000
X 0 0 00000000 0  0 0 00000000 0  0 0 00000000 0  0 0 00000000 0  10000
A 0 1 00012344 2 1 12340000 1 11111
X 0 0 00000000 0  0 0 00000000 0  0 0 00000000 0  0 0 00000000 0  00000
F 00012 0abcd 1 1 0
F 00013 0beef 1 1 1
F 00020 00777 1 0 0
F 00021 00888 1 1 0
F 00030 00999 0 1 0
# inside one page
A 1 1 00012344 2 0 00000000 0 00000
X 1 0 0abcd344 4  0 0 00000000 0  0 0 00000000 0  0 0 00000000 0  00000
A 1 1 00013ff0 3 0 00000000 0 00000
X 1 1 0beefff0 8  0 0 00000000 0  0 0 00000000 0  0 0 00000000 0  00000
# page crossing, missing and absent pages
A 1 1 00012ffe 2 1 00012ffd 2 00000
X 1 0 0abcdffe 2  1 1 0beef000 2  1 0 0abcdffd 3  1 1 0beef000 1  00000
A 1 1 00013ffc 3 0 00000000 0 00000
X 1 1 0beefffc 4  0 0 00000000 0  0 0 00000000 0  0 0 00000000 0  10000
A 1 1 00030010 0 0 00000000 0 00000
X 0 0 00000000 0  0 0 00000000 0  0 0 00000000 0  0 0 00000000 0  10000
# read-only page, then refilled writable
A 1 0 00000000 0 1 00020100 1 00000
X 0 0 00000000 0  0 0 00000000 0  1 0 00777100 2  0 0 00000000 0  01000
F 00020 00777 1 1 0
A 1 0 00000000 0 1 00020100 1 00000
X 0 0 00000000 0  0 0 00000000 0  1 0 00777100 2  0 0 00000000 0  00000
# later-stage writes
A 1 1 00012344 2 0 00000000 0 00000
ME 1 1 0abcd346 2 0 00000000 0
X 1 0 0abcd344 4  0 0 00000000 0  0 0 00000000 0  0 0 00000000 0  00100
A 1 1 00012344 2 0 00000000 0 00000
ME 0 1 0abcd346 2 0 00000000 0
X 1 0 0abcd344 4  0 0 00000000 0  0 0 00000000 0  0 0 00000000 0  00000
A 1 1 00012344 2 0 00000000 0 00000
EX 1 1 0abcd348 4 1 0abcd340 4
X 1 0 0abcd344 4  0 0 00000000 0  0 0 00000000 0  0 0 00000000 0  00000
A 1 1 00012ffe 2 0 00000000 0 00000
EX 1 0 00000000 0 1 0beef001 1
X 1 0 0abcdffe 2  1 1 0beef000 2  0 0 00000000 0  0 0 00000000 0  00100
# control store decode
A 1 0 00000000 0 0 00000000 0 10000
X 0 0 00000000 0  0 0 00000000 0  0 0 00000000 0  0 0 00000000 0  00010
A 1 0 00000000 0 0 00000000 0 01000
X 0 0 00000000 0  0 0 00000000 0  0 0 00000000 0  0 0 00000000 0  00010
A 1 0 00000000 0 0 00000000 0 00111
X 0 0 00000000 0  0 0 00000000 0  0 0 00000000 0  0 0 00000000 0  00011
A 1 0 00000000 0 0 00000000 0 00010
X 0 0 00000000 0  0 0 00000000 0  0 0 00000000 0  0 0 00000000 0  00000
A 1 0 00000000 0 0 00000000 0 00001
X 0 0 00000000 0  0 0 00000000 0  0 0 00000000 0  0 0 00000000 0  00000

//--- vlog.f
+incdir+.
mem_pkg.sv
mem_tlb.sv
mem_lsu.sv
mem_dep_check.sv
mem_stage1.sv
tb_mem_stage1.sv

//--- Makefile
TOP = tb_mem_stage1

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

lint:
	verilator --lint-only -Wall -I. mem_pkg.sv mem_tlb.sv mem_lsu.sv \
		mem_dep_check.sv mem_stage1.sv --top-module mem_stage1

clean:
	rm -rf obj_dir

//--- tb_mem_stage1.sv
`timescale 1ns/1ps
`include "mem_params.svh"

module tb_mem_stage1 import mem_pkg::*; ();

   localparam int HALF = 50;

   // one pattern record, a tlb fill or an access with its expected outputs.
   typedef struct packed {
      logic                 fill;
      logic [`VPN_BITS-1:0] vpn;
      pte_t                 pte;
      logic                 v;
      mem_req_t             rd;
      mem_req_t             wr;
      cs_mem_t              cs;
      wr_pending_t          me;
      wr_pending_t          ex;
      mem_piece_t           rd1;
      mem_piece_t           rd2;
      mem_piece_t           wr1;
      mem_piece_t           wr2;
      logic [4:0]           flags;   // page_fault gprot dep_stall jmp_stall ld_df.
   } rec_t;

   logic                  clk;
   logic                  rst_n;
   logic                  v;
   logic                  fill_en;
   logic [`VPN_BITS-1:0]  fill_vpn;
   pte_t                  fill_pte;
   mem_req_t              rd_req;
   mem_req_t              wr_req;
   cs_mem_t               cs;
   wr_pending_t           me_wr;
   wr_pending_t           ex_wr;
   mem_piece_t            rd1;
   mem_piece_t            rd2;
   mem_piece_t            wr1;
   mem_piece_t            wr2;
   logic [`ADDR_BITS-1:0] wr_addr_out;
   logic [1:0]            wr_size_out;
   logic                  wr_flag_out;
   logic                  page_fault;
   logic                  gprot;
   logic                  dep_stall;
   logic                  jmp_stall;
   logic                  ld_df;

   rec_t recs [$];
   int   err_cnt;
   int   chk_cnt;
   bit   loaded;

   mem_stage1 dut_i (.*);

   always #HALF clk = ~clk;

   // --------------------
   // helpers
   // --------------------
   function automatic mem_piece_t piece(input logic [31:0] pv, pcd, ra, sz);
      mem_piece_t p;
      p.v    = pv[0];
      p.pcd  = pcd[0];
      p.ra   = ra;
      p.size = sz[3:0];
      return p;
   endfunction

   function automatic mem_piece_t later_piece(input logic [31:0] pv, ra, sz);
      mem_piece_t p;
      p = piece(pv, 32'd0, ra, sz);
      if (!pv[0]) begin
         p.ra   = $urandom;   // dead piece, any range.
         p.size = 4'($urandom % 8 + 1);
      end
      return p;
   endfunction

   task automatic report_bad_line(input string tag);
      err_cnt++;
      $display("pattern file has a malformed %s record", tag);
   endtask

   task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
      chk_cnt++;
      if (got !== exp) begin
         err_cnt++;
         $display("error %0t ns %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic load_patterns();
      int               fd;
      int               n;
      logic [31:0]      tag;
      logic [8*128-1:0] rest;
      logic [31:0]      f [17];
      rec_t             cur;
      rec_t             fr;
      wr_pending_t      pend;
      fd = $fopen("mem_patterns.txt", "r");
      if (fd == 0) begin
         err_cnt++;
         $display("cannot open the pattern file mem_patterns.txt");
         return;
      end
      cur = '0;
      forever begin
         tag = '0;
         if ($fscanf(fd, " %s", tag) != 1) break;
         if (tag == 32'("#")) begin
            n = $fgets(rest, fd);
         end else if (tag == 32'("F")) begin
            n = $fscanf(fd, " %h %h %h %h %h", f[0], f[1], f[2], f[3], f[4]);
            if (n != 5) begin
               report_bad_line("F");
            end else begin
               fr      = '0;
               fr.fill = 1'b1;
               fr.vpn  = f[0][`VPN_BITS-1:0];
               fr.pte  = {f[1][`PFN_BITS-1:0], f[2][0], f[3][0], f[4][0]};
               recs.push_back(fr);
            end
         end else if (tag == 32'("A")) begin
            n = $fscanf(fd, " %h %h %h %h %h %h %h %b",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]);
            if (n != 8) begin
               report_bad_line("A");
            end else begin
               cur             = '0;   // no later-stage writes unless given.
               cur.v           = f[0][0];
               cur.rd.v        = f[1][0];
               cur.rd.addr.raw = f[2];
               cur.rd.size     = f[3][1:0];
               cur.wr.v        = f[4][0];
               cur.wr.addr.raw = f[5];
               cur.wr.size     = f[6][1:0];
               cur.cs          = {f[7][4:1], f[7][0], 5'($urandom)};
            end
         end else if (tag == 32'("ME") || tag == 32'("EX")) begin
            n = $fscanf(fd, " %h %h %h %h %h %h %h",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6]);
            if (n != 7) begin
               report_bad_line("ME or EX");
            end else begin
               pend.v  = f[0][0];
               pend.p1 = later_piece(f[1], f[2], f[3]);
               pend.p2 = later_piece(f[4], f[5], f[6]);
               if (tag == 32'("ME")) cur.me = pend;
               else cur.ex = pend;
            end
         end else if (tag == 32'("X")) begin
            n = $fscanf(fd, " %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %b",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                        f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16]);
            if (n != 17) begin
               report_bad_line("X");
            end else begin
               cur.rd1   = piece(f[0], f[1], f[2], f[3]);
               cur.rd2   = piece(f[4], f[5], f[6], f[7]);
               cur.wr1   = piece(f[8], f[9], f[10], f[11]);
               cur.wr2   = piece(f[12], f[13], f[14], f[15]);
               cur.flags = f[16][4:0];
               recs.push_back(cur);
            end
         end else begin
            report_bad_line("untagged");
            n = $fgets(rest, fd);
         end
      end
      $fclose(fd);
      if (recs.size() == 0) begin
         err_cnt++;
         $display("the pattern file holds no records");
      end
   endtask

   task automatic drive(input rec_t r);
      fill_en  = r.fill;
      fill_vpn = r.vpn;
      fill_pte = r.pte;
      v        = r.v;
      rd_req   = r.rd;
      wr_req   = r.wr;
      cs       = r.cs;
      me_wr    = r.me;
      ex_wr    = r.ex;
   endtask

   task automatic compare_outputs(input rec_t r);
      check("rd1", 64'(rd1), 64'(r.rd1));
      check("rd2", 64'(rd2), 64'(r.rd2));
      check("wr1", 64'(wr1), 64'(r.wr1));
      check("wr2", 64'(wr2), 64'(r.wr2));
      check("page_fault", 64'(page_fault), 64'(r.flags[4]));
      check("gprot", 64'(gprot), 64'(r.flags[3]));
      check("dep_stall", 64'(dep_stall), 64'(r.flags[2]));
      check("jmp_stall", 64'(jmp_stall), 64'(r.flags[1]));
      check("ld_df", 64'(ld_df), 64'(r.flags[0]));
      check("wr_addr_out", 64'(wr_addr_out), 64'(r.wr.addr.raw));   // pass-through.
      check("wr_size_out", 64'(wr_size_out), 64'(r.wr.size));
      check("wr_flag_out", 64'(wr_flag_out), 64'(r.wr.v));
   endtask

   // --------------------
   // run
   // --------------------
   initial begin
      void'($urandom(32'he4bcff0f));
      clk   = 1'b0;
      rst_n = 1'b0;
      drive('0);
      load_patterns();
      loaded = 1'b1;
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      foreach (recs[i]) begin
         @(negedge clk);
         drive(recs[i]);
         #(HALF - 1);   // just before the rising edge.
         if (!recs[i].fill) begin
            compare_outputs(recs[i]);
         end
      end
      @(negedge clk);
      $display("records %0d checks %0d errors %0d", recs.size(), chk_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

   initial begin
      int limit;
      wait (loaded);
      limit = (recs.size() + 10) * 2 * HALF;   // reset plus one cycle per record.
      #(limit);
      $display("timeout, the run did not end within %0d ns", limit);
      $display("TB FAILED");
      $finish;
   end

endmodule

//--- mem_stage1.sv
`timescale 1ns/1ps
`include "mem_params.svh"

module mem_stage1 import mem_pkg::*; (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  v,

   // from previous stage.
   input  mem_req_t              rd_req,
   input  mem_req_t              wr_req,
   input  cs_mem_t               cs,

   // pending writes of later stages.
   input  wr_pending_t           me_wr,
   input  wr_pending_t           ex_wr,

   // tlb fill.
   input  logic                  fill_en,
   input  logic [`VPN_BITS-1:0]  fill_vpn,
   input  pte_t                  fill_pte,

   // to next stage latches.
   output mem_piece_t            rd1,
   output mem_piece_t            rd2,
   output mem_piece_t            wr1,
   output mem_piece_t            wr2,
   output logic [`ADDR_BITS-1:0] wr_addr_out,
   output logic [1:0]            wr_size_out,
   output logic                  wr_flag_out,
   output logic                  page_fault,
   output logic                  gprot,
   output logic                  dep_stall,
   output logic                  jmp_stall,
   output logic                  ld_df
);

   mem_req_t rd_req_g;
   mem_req_t wr_req_g;
   logic     rd_page_fault;
   logic     wr_page_fault;

   // --------------------
   // request gating
   // --------------------
   always_comb begin
      rd_req_g   = rd_req;
      rd_req_g.v = v & rd_req.v;
      wr_req_g   = wr_req;
      wr_req_g.v = v & wr_req.v;
   end

   mem_lsu lsu_i (
      .clk           (clk),
      .rst_n         (rst_n),
      .rd_req        (rd_req_g),
      .wr_req        (wr_req_g),
      .fill_en       (fill_en),
      .fill_vpn      (fill_vpn),
      .fill_pte      (fill_pte),
      .rd1           (rd1),
      .rd2           (rd2),
      .wr1           (wr1),
      .wr2           (wr2),
      .rd_page_fault (rd_page_fault),
      .wr_page_fault (wr_page_fault),
      .gprot         (gprot)
   );

   assign page_fault = rd_page_fault | wr_page_fault;

   mem_dep_check dep_i (
      .v         (v),
      .rd1       (rd1),
      .rd2       (rd2),
      .me_wr     (me_wr),
      .ex_wr     (ex_wr),
      .dep_stall (dep_stall)
   );

   // --------------------
   // pass-through and decode
   // --------------------
   assign wr_addr_out = wr_req.addr.raw;
   assign wr_size_out = wr_req.size;
   assign wr_flag_out = wr_req.v;   // ungated for the latches.

   assign jmp_stall = v & (cs.jmp_stall_de | cs.is_near_ret | cs.is_far_ret);
   assign ld_df     = v & cs.ld_flags & cs.flags_affected[5];   // df is bit 5.

   // no fault, strobe or stall leaves the stage without a valid instruction.
   a_quiet_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
      !v |-> !(page_fault || gprot || jmp_stall || ld_df || dep_stall))
      else $error("stage output active while v is low");

endmodule

//--- mem_dep_check.sv
`timescale 1ns/1ps
`include "mem_params.svh"

module mem_dep_check import mem_pkg::*; (
   input  logic        v,
   input  mem_piece_t  rd1,
   input  mem_piece_t  rd2,
   input  wr_pending_t me_wr,
   input  wr_pending_t ex_wr,
   output logic        dep_stall
);

   mem_piece_t rp [2];
   mem_piece_t wp [4];
   logic [3:0] wv;
   logic [7:0] pair_hit;

   // each range starts before the other ends.
   function automatic logic overlap(input mem_piece_t a, input mem_piece_t b);
      logic [`ADDR_BITS:0] a_end;
      logic [`ADDR_BITS:0] b_end;
      a_end = {1'b0, a.ra} + (`ADDR_BITS+1)'(a.size);
      b_end = {1'b0, b.ra} + (`ADDR_BITS+1)'(b.size);
      return ({1'b0, a.ra} < b_end) && ({1'b0, b.ra} < a_end);
   endfunction

   // --------------------
   // operand lists
   // --------------------
   always_comb begin
      rp[0] = rd1;
      rp[1] = rd2;
      wp[0] = me_wr.p1;
      wp[1] = me_wr.p2;
      wp[2] = ex_wr.p1;
      wp[3] = ex_wr.p2;
      wv[0] = me_wr.v & me_wr.p1.v;   // stage valid gates its pieces.
      wv[1] = me_wr.v & me_wr.p2.v;
      wv[2] = ex_wr.v & ex_wr.p1.v;
      wv[3] = ex_wr.v & ex_wr.p2.v;
   end

   // --------------------
   // pairwise compares
   // --------------------
   always_comb begin
      for (int r = 0; r < 2; r++) begin
         for (int w = 0; w < 4; w++) begin
            pair_hit[r*4 + w] = rp[r].v && wv[w] && overlap(rp[r], wp[w]);
         end
      end
   end

   assign dep_stall = v && (|pair_hit);

endmodule

//--- mem_lsu.sv
`timescale 1ns/1ps
`include "mem_params.svh"

module mem_lsu import mem_pkg::*; (
   input  logic                 clk,
   input  logic                 rst_n,
   input  mem_req_t             rd_req,
   input  mem_req_t             wr_req,
   input  logic                 fill_en,
   input  logic [`VPN_BITS-1:0] fill_vpn,
   input  pte_t                 fill_pte,
   output mem_piece_t           rd1,
   output mem_piece_t           rd2,
   output mem_piece_t           wr1,
   output mem_piece_t           wr2,
   output logic                 rd_page_fault,
   output logic                 wr_page_fault,
   output logic                 gprot
);

   localparam int OFF_W = `PAGE_BITS + 1;

   lin_addr_u            rd_la1, rd_la2, wr_la1, wr_la2;
   logic [3:0]           rd_n1, rd_n2, wr_n1, wr_n2;
   logic                 rd_e2, wr_e2;
   logic [`VPN_BITS-1:0] look_vpn [4];
   logic [3:0]           hit;
   pte_t                 pte [4];
   logic [3:0]           miss;

   function automatic logic [3:0] byte_cnt(input logic [1:0] size);
      return 4'd1 << size;
   endfunction

   // --------------------
   // page split
   // --------------------
   function automatic void split_access(
      input  mem_req_t   req,
      output lin_addr_u  la1,
      output logic [3:0] n1,
      output logic       e2,
      output lin_addr_u  la2,
      output logic [3:0] n2
   );
      logic [3:0]       n;
      logic [OFF_W-1:0] end_off;
      n       = byte_cnt(req.size);
      end_off = OFF_W'(req.addr.pg.off) + OFF_W'(n);
      la1     = req.addr;
      e2      = end_off > OFF_W'(`PAGE_SIZE);
      if (e2) begin
         n1         = 4'(`PAGE_SIZE - int'(req.addr.pg.off));   // up to page end.
         n2         = n - n1;
         la2.pg.vpn = req.addr.pg.vpn + 1'b1;
         la2.pg.off = '0;
      end else begin
         n1  = n;
         n2  = '0;
         la2 = '0;
      end
   endfunction

   always_comb begin
      split_access(rd_req, rd_la1, rd_n1, rd_e2, rd_la2, rd_n2);
      split_access(wr_req, wr_la1, wr_n1, wr_e2, wr_la2, wr_n2);
   end

   assign look_vpn[0] = rd_la1.pg.vpn;
   assign look_vpn[1] = rd_la2.pg.vpn;
   assign look_vpn[2] = wr_la1.pg.vpn;
   assign look_vpn[3] = wr_la2.pg.vpn;

   mem_tlb tlb_i (
      .clk      (clk),
      .rst_n    (rst_n),
      .fill_en  (fill_en),
      .fill_vpn (fill_vpn),
      .fill_pte (fill_pte),
      .look_vpn (look_vpn),
      .hit      (hit),
      .pte      (pte)
   );

   // --------------------
   // translate and fault
   // --------------------
   function automatic mem_piece_t xlate(input logic ok, input lin_addr_u la,
                                        input logic [3:0] n, input logic h, input pte_t e);
      mem_piece_t pc;
      pc = '0;   // invalid pieces read as zero.
      if (ok && h && e.present) begin
         pc.v    = 1'b1;
         pc.pcd  = e.pcd;
         pc.ra   = {e.pfn, la.pg.off};
         pc.size = n;
      end
      return pc;
   endfunction

   always_comb begin
      rd1 = xlate(rd_req.v, rd_la1, rd_n1, hit[0], pte[0]);
      rd2 = xlate(rd1.v && rd_e2, rd_la2, rd_n2, hit[1], pte[1]);
      wr1 = xlate(wr_req.v, wr_la1, wr_n1, hit[2], pte[2]);
      wr2 = xlate(wr1.v && wr_e2, wr_la2, wr_n2, hit[3], pte[3]);

      miss[0] = rd_req.v && !(hit[0] && pte[0].present);
      miss[1] = rd_req.v && rd_e2 && !(hit[1] && pte[1].present);
      miss[2] = wr_req.v && !(hit[2] && pte[2].present);
      miss[3] = wr_req.v && wr_e2 && !(hit[3] && pte[3].present);
   end

   assign rd_page_fault = miss[0] | miss[1];
   assign wr_page_fault = miss[2] | miss[3];
   assign gprot = (wr1.v && !pte[2].rw) || (wr2.v && !pte[3].rw);   // read-only page.

   a_rd_order: assert property (@(posedge clk) disable iff (!rst_n) rd2.v |-> rd1.v);
   a_wr_order: assert property (@(posedge clk) disable iff (!rst_n) wr2.v |-> wr1.v);

   // a fully translated access covers exactly the requested bytes.
   a_rd_sum: assert property (@(posedge clk) disable iff (!rst_n)
      rd1.v && !rd_page_fault |->
         5'(rd1.size) + 5'(rd2.size) == 5'(byte_cnt(rd_req.size)));
   a_wr_sum: assert property (@(posedge clk) disable iff (!rst_n)
      wr1.v && !wr_page_fault |->
         5'(wr1.size) + 5'(wr2.size) == 5'(byte_cnt(wr_req.size)));

endmodule

//--- mem_tlb.sv
`timescale 1ns/1ps
`include "mem_params.svh"

module mem_tlb import mem_pkg::*; (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 fill_en,
   input  logic [`VPN_BITS-1:0] fill_vpn,
   input  pte_t                 fill_pte,
   input  logic [`VPN_BITS-1:0] look_vpn [4],
   output logic [3:0]           hit,
   output pte_t                 pte [4]
);

   localparam int IDX_BITS = $clog2(`TLB_ENTRIES);

   logic [`TLB_ENTRIES-1:0] ent_v;
   logic [`VPN_BITS-1:0]    ent_vpn [`TLB_ENTRIES];
   pte_t                    ent_pte [`TLB_ENTRIES];
   logic [IDX_BITS-1:0]     rr_ptr;
   logic                    fill_match;
   logic [IDX_BITS-1:0]     fill_idx;
   logic                    dup_vpn;

   // --------------------
   // fill
   // --------------------
   always_comb begin
      fill_match = 1'b0;
      fill_idx   = rr_ptr;   // round-robin victim.
      for (int i = 0; i < `TLB_ENTRIES; i++) begin
         if (ent_v[i] && ent_vpn[i] == fill_vpn) begin
            fill_match = 1'b1;
            fill_idx   = IDX_BITS'(i);   // same vpn, overwrite in place.
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ent_v  <= '0;
         rr_ptr <= '0;
      end else if (fill_en) begin
         ent_v[fill_idx] <= 1'b1;
         if (!fill_match) begin
            rr_ptr <= rr_ptr + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (fill_en) begin
         ent_vpn[fill_idx] <= fill_vpn;
         ent_pte[fill_idx] <= fill_pte;
      end
   end

   // --------------------
   // lookup
   // --------------------
   always_comb begin
      for (int p = 0; p < 4; p++) begin
         hit[p] = 1'b0;
         pte[p] = '0;
         for (int i = 0; i < `TLB_ENTRIES; i++) begin
            if (ent_v[i] && ent_vpn[i] == look_vpn[p]) begin
               hit[p] = 1'b1;
               pte[p] = ent_pte[i];
            end
         end
      end
   end

   always_comb begin
      dup_vpn = 1'b0;
      for (int i = 0; i < `TLB_ENTRIES; i++) begin
         for (int j = i + 1; j < `TLB_ENTRIES; j++) begin
            if (ent_v[i] && ent_v[j] && ent_vpn[i] == ent_vpn[j]) begin
               dup_vpn = 1'b1;
            end
         end
      end
   end

   // refills must never leave a vpn in two entries.
   a_uniq_vpn: assert property (@(posedge clk) disable iff (!rst_n) !dup_vpn)
      else $error("tlb holds one vpn in two valid entries");

endmodule

//--- mem_pkg.sv
package mem_pkg;
`include "mem_params.svh"

   // --------------------
   // addresses and pages
   // --------------------
   typedef struct packed {
      logic [`VPN_BITS-1:0]  vpn;
      logic [`PAGE_BITS-1:0] off;
   } lin_addr_s;

   // linear address, raw or split into page and offset.
   typedef union packed {
      logic [`ADDR_BITS-1:0] raw;
      lin_addr_s             pg;
   } lin_addr_u;

   typedef struct packed {
      logic [`PFN_BITS-1:0] pfn;
      logic                 present;
      logic                 rw;      // write allowed.
      logic                 pcd;
   } pte_t;

   // --------------------
   // accesses
   // --------------------
   typedef struct packed {
      logic       v;
      lin_addr_u  addr;
      logic [1:0] size;   // 1, 2, 4 or 8 bytes.
   } mem_req_t;

   typedef struct packed {
      logic                  v;
      logic                  pcd;
      logic [`ADDR_BITS-1:0] ra;
      logic [3:0]            size;   // byte count.
   } mem_piece_t;

   typedef struct packed {
      logic       v;
      mem_piece_t p1;
      mem_piece_t p2;
   } wr_pending_t;

   // control store fields read by this stage.
   typedef struct packed {
      logic       jmp_stall_de;
      logic       is_near_ret;
      logic       is_far_ret;
      logic       ld_flags;
      logic [5:0] flags_affected;
   } cs_mem_t;

endpackage

//--- mem_params.svh
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// --------------------
// paging geometry
// --------------------
`define PAGE_BITS 12
`define PAGE_SIZE (1 << `PAGE_BITS)

// --------------------
// tlb and addresses
// --------------------
`define TLB_ENTRIES 8
`define VPN_BITS 20
`define PFN_BITS 20
`define ADDR_BITS 32

`endif
